//--- sim.f
lin_pkg.sv
lin_bit_timer.sv
lin_tx.sv
lin_rx.sv
lin_master_fsm.sv
lin_ctrl.sv
tb_clk_gen.sv
tb_lin_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lin_ctrl
FLIST     ?= sim.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD VFLAGS"

$(BUILD)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

test: $(BUILD)/V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD)

//--- tb_lin_ctrl.sv
// bus decoding assumes bit_time of 2 us at 100 MHz; the slave model pulls the wired-AND bus low
`timescale 1ns/1ps

module tb_lin_ctrl
  import lin_pkg::*;
;

  localparam bit_time_t BIT_US   = 10'd2;
  localparam int BIT_CYC         = 200;      // cycles per bit at 2 us
  localparam int CYCLE_LIMIT     = 400000;   // six frames of ~130 bits, with margin

  logic     clk;
  logic     rst;
  lin_req_t req;
  logic     req_valid;
  logic     req_ready;
  lin_rsp_t rsp;
  logic     rsp_valid;
  logic     rsp_ready;
  logic     dut_tx;
  logic     slave_tx;                        // testbench slave drive
  logic     bus;
  int       cycle_cnt;
  int       checks;
  int       errors;
  integer   seed;

  assign bus = dut_tx & slave_tx;            // wired-AND

  tb_clk_gen u_clk (.clk(clk), .rst(rst));

  lin_ctrl dut (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .lin_rx    (bus),
    .lin_tx    (dut_tx)
  );

  // ----------------------------------------------------------------------
  // check helpers and reference model
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1)
    else
    begin
      errors++;
      $display("ERROR: %s", what);
    end
  endtask

  // parity bits on top of the 6-bit id
  function automatic logic [7:0] make_pid(input logic [5:0] id);
    logic p0;
    logic p1;
    p0 = id[0] ^ id[1] ^ id[2] ^ id[4];
    p1 = !(id[1] ^ id[3] ^ id[4] ^ id[5]);
    return {p1, p0, id};
  endfunction

  // sum of the first n bytes, top byte first, carry folded back in
  function automatic logic [7:0] byte_sum(input logic [63:0] data, input int n,
                                          input logic [7:0] start);
    int acc;
    acc = start;
    for (int i = 0; i < n; i++)
    begin
      acc = acc + data[63-8*i -: 8];
      if (acc > 255)
        acc = acc - 255;
    end
    return acc[7:0];
  endfunction

  // ----------------------------------------------------------------------
  // bus side: decoder and slave responder
  // ----------------------------------------------------------------------
  task automatic measure_break();
    int n;
    int low_cnt;
    n = 0;
    low_cnt = 0;
    while (bus !== 1'b0 && n < 4 * BIT_CYC)
    begin
      @(negedge clk);
      n++;
    end
    while (bus === 1'b0 && low_cnt < 20 * BIT_CYC)
    begin
      @(negedge clk);
      low_cnt++;
    end
    check_true(low_cnt >= BREAK_BITS * BIT_CYC - 2, "break shorter than 13 bits");  // edge granularity
  endtask

  task automatic read_byte(output logic [7:0] b);
    int n;
    n = 0;
    b = '0;
    while (bus !== 1'b0 && n < 20 * BIT_CYC)
    begin
      @(negedge clk);
      n++;
    end
    check_true(bus === 1'b0, "no start bit seen on the bus");
    repeat (BIT_CYC / 2) @(negedge clk);   // mid start bit
    check_true(bus === 1'b0, "start bit not dominant at mid-bit");
    for (int i = 0; i < 8; i++)
    begin
      repeat (BIT_CYC) @(negedge clk);
      b[i] = bus;                           // lsb first
    end
    repeat (BIT_CYC) @(negedge clk);
    check_true(bus === 1'b1, "stop bit on the bus is dominant");
  endtask

  task automatic read_header(input logic [5:0] id);
    logic [7:0] b;
    measure_break();
    read_byte(b);
    check_value("sync", b, SYNC_BYTE);
    read_byte(b);
    check_value("pid", b, make_pid(id));
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};                // stop, data, start
    for (int i = 0; i < 10; i++)
    begin
      @(posedge clk);
      slave_tx <= frame[i];
      repeat (BIT_CYC - 1) @(posedge clk);
    end
    @(posedge clk);
    slave_tx <= 1'b1;
  endtask

  // ----------------------------------------------------------------------
  // request and result handshakes
  // ----------------------------------------------------------------------
  task automatic send_request(input lin_op_t op, input logic [5:0] id, input logic [63:0] data,
                              input logic enh);
    @(posedge clk);
    req       <= '{op: op, id: id, data: data, enhanced: enh, bit_time: BIT_US};
    req_valid <= 1'b1;
    do
      @(posedge clk);
    while (!req_ready);                      // taken on this edge
    req_valid <= 1'b0;
  endtask

  task automatic await_rsp(input int limit);
    int n;
    n = 0;
    while (!rsp_valid && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    check_true(rsp_valid, "no result record within the expected time");
  endtask

  task automatic release_rsp();
    @(posedge clk);
    rsp_ready <= 1'b1;
    @(posedge clk);
    rsp_ready <= 1'b0;
    @(negedge clk);
    check_value("rsp_valid", rsp_valid, 1'b0);
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic test_reset();
    @(negedge clk);
    check_value("lin_tx", dut_tx, 1'b1);   // during reset
    @(negedge rst);
    @(negedge clk);
    check_value("lin_tx", dut_tx, 1'b1);
    check_value("rsp_valid", rsp_valid, 1'b0);
    check_value("req_ready", req_ready, 1'b1);
  endtask

  task automatic test_publish();
    logic [63:0] data;
    logic [7:0]  b;
    logic [7:0]  cks;
    logic [7:0]  exp_cks;
    lin_rsp_t    held;
    logic        stable;
    data    = {$random(seed), $random(seed)};
    exp_cks = ~byte_sum(data, 2, 8'h00);
    send_request(OP_PUBLISH, 6'h10, data, 1'b0);
    read_header(6'h10);
    read_byte(b);
    check_value("data0", b, data[63:56]);
    read_byte(b);
    check_value("data1", b, data[55:48]);
    read_byte(cks);
    check_value("cks_bus", cks, exp_cks);
    await_rsp(2 * BIT_CYC);
    held   = rsp;
    stable = 1'b1;
    repeat (50)                              // back-pressure window
    begin
      @(negedge clk);
      if (rsp !== held || req_ready !== 1'b0 || rsp_valid !== 1'b1)
        stable = 1'b0;
    end
    check_true(stable, "result changed or req_ready rose under back-pressure");
    check_value("rsp.err", rsp.err, 4'h0);
    check_value("rsp.cks", rsp.cks, cks);
    check_value("rsp.pid", rsp.pid, make_pid(6'h10));
    release_rsp();
  endtask

  task automatic test_subscribe(input logic [5:0] id, input int len, input logic enh,
                                input logic bad_cks);
    logic [63:0] data;
    logic [63:0] exp;
    logic [7:0]  cks;
    data = {$random(seed), $random(seed)};
    exp  = (len == 8) ? data : {data[63:32], 32'h0};
    cks  = ~byte_sum(data, len, enh ? make_pid(id) : 8'h00);
    if (bad_cks)
      cks = cks ^ 8'h01;                     // corrupt one bit
    send_request(OP_SUBSCRIBE, id, 64'h0, enh);
    read_header(id);
    repeat (BIT_CYC) @(posedge clk);         // one bit of gap
    for (int i = 0; i < len; i++)
      send_byte(data[63-8*i -: 8]);
    send_byte(cks);
    await_rsp(2 * BIT_CYC);
    check_value("rsp.data", rsp.data, exp);
    check_value("rsp.cks", rsp.cks, cks);
    check_value("rsp.err", rsp.err, bad_cks ? 4'h1 : 4'h0);
    release_rsp();
  endtask

  task automatic test_no_answer();
    send_request(OP_SUBSCRIBE, 6'h01, 64'h0, 1'b0);
    read_header(6'h01);
    await_rsp((RESP_TIMEOUT_BITS + 2) * BIT_CYC);
    check_value("rsp.err", rsp.err, 4'h8);
    check_value("rsp.pid", rsp.pid, make_pid(6'h01));
    release_rsp();
    check_value("req_ready", req_ready, 1'b1);
  endtask

  task automatic test_bit_error();
    int n;
    n = 0;
    send_request(OP_PUBLISH, 6'h05, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0);
    read_header(6'h05);
    while (bus !== 1'b0 && n < 4 * BIT_CYC)  // start of first data byte
    begin
      @(negedge clk);
      n++;
    end
    @(posedge clk);
    repeat (BIT_CYC * 3 / 4) @(posedge clk);
    slave_tx <= 1'b0;                        // covers mid of recessive data bit 0
    repeat (BIT_CYC) @(posedge clk);
    slave_tx <= 1'b1;
    await_rsp(2 * BIT_CYC);
    check_value("rsp.err", rsp.err, 4'h4);
    @(negedge clk);
    check_value("lin_tx", dut_tx, 1'b1);
    release_rsp();
  endtask

  // ----------------------------------------------------------------------
  // run control
  // ----------------------------------------------------------------------
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT)
    begin
      $display("run stopped: cycle limit of %0d reached", CYCLE_LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  initial
  begin
    req       = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b0;
    slave_tx  = 1'b1;                        // slave idles recessive
    cycle_cnt = 0;
    checks    = 0;
    errors    = 0;
    seed      = 32'h695d07df;
    test_reset();
    test_publish();
    test_subscribe(6'h30, 8, 1'b1, 1'b0);
    test_subscribe(6'h20, 4, 1'b0, 1'b1);
    test_no_answer();
    test_bit_error();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
// free-running 100 MHz clock; rst is high from time zero for the first 4 rising edges
`timescale 1ns/1ps

module tb_clk_gen
(
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;                   // 10 ns period
  end

  initial
  begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;                             // release after 4 cycles
  end

endmodule

//--- lin_ctrl.sv
// single channel master only; lin_rx must see the wired-AND bus including this node's lin_tx
`timescale 1ns/1ps

module lin_ctrl
  import lin_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  lin_req_t req,
  input  logic     req_valid,
  output logic     req_ready,
  output lin_rsp_t rsp,
  output logic     rsp_valid,
  input  logic     rsp_ready,
  input  logic     lin_rx,                   // bus from transceiver
  output logic     lin_tx                    // drive to transceiver
);

  logic       restart;
  bit_time_t  bit_time;
  logic       bit_tick;
  logic       sample_tick;
  logic       break_start;
  logic       byte_load;
  logic [7:0] tx_byte;
  logic       tx_done;
  logic       bit_err;
  logic       rx_line;
  logic       armed;
  logic       start_edge;
  logic       rx_done;
  logic [7:0] rx_byte;
  logic       stop_err;

  lin_bit_timer u_timer (
    .clk         (clk),
    .rst         (rst),
    .restart     (restart),
    .bit_time    (bit_time),
    .bit_tick    (bit_tick),
    .sample_tick (sample_tick)
  );

  lin_tx u_tx (
    .clk         (clk),
    .rst         (rst),
    .bit_tick    (bit_tick),
    .sample_tick (sample_tick),
    .break_start (break_start),
    .byte_load   (byte_load),
    .tx_byte     (tx_byte),
    .rx_line     (rx_line),                  // readback path
    .tx_done     (tx_done),
    .bit_err     (bit_err),
    .lin_tx      (lin_tx)
  );

  lin_rx u_rx (
    .clk         (clk),
    .rst         (rst),
    .lin_rx      (lin_rx),
    .sample_tick (sample_tick),
    .armed       (armed),
    .rx_line     (rx_line),
    .start_edge  (start_edge),
    .rx_done     (rx_done),
    .rx_byte     (rx_byte),
    .stop_err    (stop_err)
  );

  lin_master_fsm u_fsm (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .rsp         (rsp),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .restart     (restart),
    .bit_time    (bit_time),
    .bit_tick    (bit_tick),
    .break_start (break_start),
    .byte_load   (byte_load),
    .tx_byte     (tx_byte),
    .tx_done     (tx_done),
    .bit_err     (bit_err),
    .armed       (armed),
    .start_edge  (start_edge),
    .rx_done     (rx_done),
    .rx_byte     (rx_byte),
    .stop_err    (stop_err)
  );

endmodule

//--- lin_master_fsm.sv
// one frame at a time; rsp holds until rsp_ready, and no new request is taken before that
`timescale 1ns/1ps

module lin_master_fsm
  import lin_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  lin_req_t   req,
  input  logic       req_valid,
  output logic       req_ready,
  output lin_rsp_t   rsp,
  output logic       rsp_valid,
  input  logic       rsp_ready,
  output logic       restart,                // to bit timer
  output bit_time_t  bit_time,
  input  logic       bit_tick,
  output logic       break_start,
  output logic       byte_load,
  output logic [7:0] tx_byte,
  input  logic       tx_done,
  input  logic       bit_err,
  output logic       armed,
  input  logic       start_edge,
  input  logic       rx_done,
  input  logic [7:0] rx_byte,
  input  logic       stop_err
);

  typedef enum logic [3:0] {
    S_IDLE, S_BREAK, S_SYNC, S_PID, S_DECIDE,
    S_TX_DATA, S_TX_CKS, S_WAIT_DATA, S_RX_DATA, S_WAIT_CKS, S_RX_CKS, S_DONE
  } state_t;

  state_t            state;
  state_t            state_nxt;
  lin_op_t           op_q;
  logic              enh_q;                  // enhanced checksum
  logic [7:0]        pid_q;
  logic [3:0]        len_q;                  // data bytes
  logic [63:0]       data_q;                 // sent or received data
  logic [3:0]        byte_cnt;
  logic [7:0]        cks_q;                  // running sum
  logic [TOUT_W-1:0] tout_cnt;               // bit times spent waiting
  logic [7:0]        pid_calc;
  logic [3:0]        len_calc;
  logic [7:0]        data_byte;
  logic [7:0]        cks_out;
  logic              cks_last;
  logic              accept;
  logic              data_load;
  logic              rx_store;
  logic              in_wait;
  logic              in_tx;
  lin_err_t          err_now;

  // 8-bit sum with end-around carry
  function automatic logic [7:0] cks_add(input logic [7:0] acc, input logic [7:0] b);
    logic [8:0] sum;
    sum = {1'b0, acc} + {1'b0, b};
    return sum[7:0] + {7'd0, sum[8]};
  endfunction

  // ----------------------------------------------------------------------
  // frame decode
  // ----------------------------------------------------------------------
  assign pid_calc = {~(req.id[1] ^ req.id[3] ^ req.id[4] ^ req.id[5]),  // p1
                     req.id[0] ^ req.id[1] ^ req.id[2] ^ req.id[4],     // p0
                     req.id};
  assign len_calc = (req.id >= ID_LEN8_MIN) ? 4'd8 :
                    (req.id >= ID_LEN4_MIN) ? 4'd4 : 4'd2;

  assign accept    = (state == S_IDLE) && req_valid;
  assign data_byte = data_q[{~byte_cnt[2:0], 3'b000} +: 8];  // byte 0 is 63..56
  assign cks_last  = (byte_cnt == len_q);
  assign in_wait   = (state == S_WAIT_DATA) || (state == S_WAIT_CKS);
  assign in_tx     = (state == S_BREAK) || (state == S_SYNC) || (state == S_PID) ||
                     (state == S_TX_DATA) || (state == S_TX_CKS);
  assign armed     = (state == S_RX_DATA) || (state == S_RX_CKS);
  assign data_load = byte_load && ((state == S_DECIDE) || ((state == S_TX_DATA) && !cks_last));
  assign rx_store  = (state == S_RX_DATA) && rx_done && !stop_err;

  assign err_now.timeout  = in_wait && (tout_cnt == TOUT_LAST);
  assign err_now.bit_err  = in_tx && bit_err;
  assign err_now.stop_err = armed && rx_done && stop_err;
  assign err_now.cks_err  = (state == S_RX_CKS) && rx_done &&
                            (cks_add(cks_q, rx_byte) != 8'hFF);  // sum plus cks is ff

  // ----------------------------------------------------------------------
  // sequencer
  // ----------------------------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    if (|err_now)
      state_nxt = S_DONE;                    // first error ends the frame
    else
    begin
      case (state)
        S_IDLE:      state_nxt = accept ? S_BREAK : S_IDLE;
        S_BREAK:     state_nxt = tx_done ? S_SYNC : S_BREAK;
        S_SYNC:      state_nxt = tx_done ? S_PID : S_SYNC;
        S_PID:       state_nxt = tx_done ? S_DECIDE : S_PID;
        S_DECIDE:    state_nxt = (op_q == OP_PUBLISH) ? S_TX_DATA : S_WAIT_DATA;
        S_TX_DATA:   state_nxt = (tx_done && cks_last) ? S_TX_CKS : S_TX_DATA;
        S_TX_CKS:    state_nxt = tx_done ? S_DONE : S_TX_CKS;
        S_WAIT_DATA: state_nxt = start_edge ? S_RX_DATA : S_WAIT_DATA;
        S_RX_DATA:
        begin
          if (rx_done)
            state_nxt = (byte_cnt + 4'd1 == len_q) ? S_WAIT_CKS : S_WAIT_DATA;
        end
        S_WAIT_CKS:  state_nxt = start_edge ? S_RX_CKS : S_WAIT_CKS;
        S_RX_CKS:    state_nxt = rx_done ? S_DONE : S_RX_CKS;
        S_DONE:      state_nxt = rsp_ready ? S_IDLE : S_DONE;  // hold under back-pressure
        default:     state_nxt = S_IDLE;
      endcase
    end
  end

  assign restart     = (state != state_nxt);
  assign req_ready   = (state == S_IDLE);
  assign break_start = accept;

  always_comb
  begin
    case (state)
      S_BREAK, S_SYNC, S_TX_DATA: byte_load = tx_done;  // next byte right after stop
      S_DECIDE:                   byte_load = (op_q == OP_PUBLISH);
      default:                    byte_load = 1'b0;
    endcase
  end

  always_comb
  begin
    case (state)
      S_BREAK:   tx_byte = SYNC_BYTE;
      S_SYNC:    tx_byte = pid_q;
      S_TX_DATA: tx_byte = cks_last ? ~cks_q : data_byte;  // inverted sum last
      default:   tx_byte = data_byte;
    endcase
  end

  always_comb
  begin
    if (op_q == OP_PUBLISH)
      cks_out = ~cks_q;
    else if (state == S_RX_CKS)
      cks_out = rx_byte;
    else
      cks_out = '0;                          // no checksum arrived
  end

  // ----------------------------------------------------------------------
  // control registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state     <= S_IDLE;
      byte_cnt  <= '0;
      tout_cnt  <= '0;
      rsp_valid <= 1'b0;
      bit_time  <= BIT_TIME_DEFAULT;
    end
    else
    begin
      state <= state_nxt;
      if (accept)
      begin
        byte_cnt <= '0;
        bit_time <= req.bit_time;
      end
      else if (data_load || rx_store)
        byte_cnt <= byte_cnt + 1'b1;
      if (restart)
        tout_cnt <= '0;
      else if (in_wait && bit_tick)
        tout_cnt <= tout_cnt + 1'b1;
      if ((state_nxt == S_DONE) && (state != S_DONE))
        rsp_valid <= 1'b1;
      else if (rsp_valid && rsp_ready)
        rsp_valid <= 1'b0;
    end
  end

  // frame payload and result record
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      op_q   <= req.op;
      enh_q  <= req.enhanced;
      pid_q  <= pid_calc;
      len_q  <= len_calc;
      data_q <= (req.op == OP_PUBLISH) ? req.data : '0;
      cks_q  <= '0;
    end
    else if ((state == S_PID) && tx_done && enh_q)
      cks_q <= cks_add(cks_q, pid_q);
    else if (data_load)
      cks_q <= cks_add(cks_q, data_byte);
    else if (rx_store)
    begin
      data_q[{~byte_cnt[2:0], 3'b000} +: 8] <= rx_byte;  // left-justified
      cks_q <= cks_add(cks_q, rx_byte);
    end
    if ((state_nxt == S_DONE) && (state != S_DONE))
      rsp <= '{pid: pid_q, data: data_q, cks: cks_out, err: err_now};
  end

endmodule

//--- lin_rx.sv
// sampling needs the bit timer restarted at start_edge; armed low clears the bit index
`timescale 1ns/1ps

module lin_rx
  import lin_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       lin_rx,                 // raw bus from transceiver
  input  logic       sample_tick,
  input  logic       armed,                  // receive one byte
  output logic       rx_line,
  output logic       start_edge,
  output logic       rx_done,
  output logic [7:0] rx_byte,
  output logic       stop_err
);

  logic       sync1;
  logic       sync2;
  logic       line_prev;                     // for edge detect
  logic [3:0] bit_idx;                       // 0 start, 1..8 data, 9 stop
  logic [7:0] shift;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      sync1     <= 1'b1;                     // bus idles recessive
      sync2     <= 1'b1;
      line_prev <= 1'b1;
    end
    else
    begin
      sync1     <= lin_rx;
      sync2     <= sync1;
      line_prev <= sync2;
    end
  end

  assign rx_line    = sync2;
  assign start_edge = line_prev & ~sync2;    // falling edge

  // ----------------------------------------------------------------------
  // byte sampling
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      bit_idx  <= '0;
      rx_done  <= 1'b0;
      stop_err <= 1'b0;
    end
    else
    begin
      rx_done  <= 1'b0;
      stop_err <= 1'b0;
      if (!armed)
        bit_idx <= '0;
      else if (sample_tick)
      begin
        if (bit_idx == BYTE_LAST)
        begin
          bit_idx  <= '0;
          rx_done  <= 1'b1;
          stop_err <= ~sync2;                // stop must be recessive
        end
        else
          bit_idx <= bit_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (armed && sample_tick && (bit_idx != '0) && (bit_idx != BYTE_LAST))
      shift <= {sync2, shift[7:1]};          // lsb arrives first
  end

  assign rx_byte = shift;

endmodule

//--- lin_tx.sv
// break_start and byte_load must only come while idle or on tx_done; bit_err drops the frame
`timescale 1ns/1ps

module lin_tx
  import lin_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       bit_tick,
  input  logic       sample_tick,
  input  logic       break_start,
  input  logic       byte_load,
  input  logic [7:0] tx_byte,
  input  logic       rx_line,                // synchronized bus for readback
  output logic       tx_done,
  output logic       bit_err,
  output logic       lin_tx
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_BREAK,
    TX_BYTE
  } tx_mode_t;

  tx_mode_t   mode;
  logic [3:0] bit_cnt;                       // bit index in break or byte
  logic [9:0] shift;                         // stop, data, start
  logic       last_bit;

  assign last_bit = (mode == TX_BREAK) ? (bit_cnt == BREAK_LAST) : (bit_cnt == BYTE_LAST);
  assign tx_done  = (mode != TX_IDLE) && bit_tick && last_bit;

  // bus level from mode, recessive when idle
  always_comb
  begin
    case (mode)
      TX_BREAK: lin_tx = (bit_cnt == BREAK_LAST);  // dominant until delimiter
      TX_BYTE:  lin_tx = shift[0];
      default:  lin_tx = 1'b1;
    endcase
  end

  // ----------------------------------------------------------------------
  // bit sequencing and readback
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      mode    <= TX_IDLE;
      bit_cnt <= '0;
      bit_err <= 1'b0;
    end
    else
    begin
      bit_err <= 1'b0;                       // single pulse
      if (break_start)
      begin
        mode    <= TX_BREAK;
        bit_cnt <= '0;
      end
      else if (byte_load)
      begin
        mode    <= TX_BYTE;
        bit_cnt <= '0;
      end
      else if (mode != TX_IDLE)
      begin
        if (sample_tick && (rx_line != lin_tx))
        begin
          bit_err <= 1'b1;
          mode    <= TX_IDLE;                // release bus
        end
        else if (bit_tick)
        begin
          if (last_bit)
            mode <= TX_IDLE;
          else
            bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (byte_load)
      shift <= {1'b1, tx_byte, 1'b0};        // lsb first after start bit
    else if (bit_tick)
      shift <= {1'b1, shift[9:1]};
  end

endmodule

//--- lin_bit_timer.sv
// both ticks are combinational from the counters; restart zeroes them, so bit 0 starts next cycle
`timescale 1ns/1ps

module lin_bit_timer
  import lin_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      restart,                 // realign to current cycle
  input  bit_time_t bit_time,
  output logic      bit_tick,                // last cycle of a bit
  output logic      sample_tick              // middle of a bit
);

  logic [CYC_W-1:0] cyc_cnt;                 // cycles within one us
  bit_time_t        us_cnt;                  // us within one bit
  logic             us_wrap;

  assign us_wrap = (cyc_cnt == CYC_LAST);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      cyc_cnt <= '0;
      us_cnt  <= '0;
    end
    else if (restart)
    begin
      cyc_cnt <= '0;
      us_cnt  <= '0;
    end
    else if (us_wrap)
    begin
      cyc_cnt <= '0;
      us_cnt  <= bit_tick ? '0 : us_cnt + 1'b1;  // wrap at bit_time
    end
    else
    begin
      cyc_cnt <= cyc_cnt + 1'b1;
    end
  end

  assign bit_tick    = us_wrap && (us_cnt == bit_time - 1'b1);
  assign sample_tick = (cyc_cnt == '0) && (us_cnt == (bit_time >> 1));  // half bit in

endmodule

//--- lin_pkg.sv
// constants assume a 100 MHz clk; bit_time below 2 us is too short for mid-bit sampling
package lin_pkg;

  // ----------------------------------------------------------------------
  // timing
  // ----------------------------------------------------------------------
  localparam int CYCLES_PER_US     = 100;                     // 100 MHz clk
  localparam int BREAK_BITS        = 13;                      // dominant bits in break
  localparam int RESP_TIMEOUT_BITS = 14;                      // bit times per response byte
  localparam int CYC_W             = $clog2(CYCLES_PER_US);
  localparam logic [CYC_W-1:0] CYC_LAST = CYC_W'(CYCLES_PER_US - 1);
  localparam int TOUT_W            = $clog2(RESP_TIMEOUT_BITS + 1);
  localparam logic [TOUT_W-1:0] TOUT_LAST = TOUT_W'(RESP_TIMEOUT_BITS);
  localparam logic [3:0] BREAK_LAST = 4'(BREAK_BITS);        // index of delimiter bit
  localparam logic [3:0] BYTE_LAST  = 4'd9;                   // index of stop bit

  // ----------------------------------------------------------------------
  // frame fields
  // ----------------------------------------------------------------------
  localparam logic [7:0] SYNC_BYTE   = 8'h55;
  localparam logic [5:0] ID_LEN4_MIN = 6'd32;                 // ids 32..47 carry 4 bytes
  localparam logic [5:0] ID_LEN8_MIN = 6'd48;                 // ids 48..63 carry 8 bytes

  typedef logic [9:0] bit_time_t;                             // bit period in us
  localparam bit_time_t BIT_TIME_DEFAULT = 10'd50;            // 20 kbit/s

  typedef enum logic {
    OP_PUBLISH   = 1'b0,                                      // master sends response
    OP_SUBSCRIBE = 1'b1                                       // slave sends response
  } lin_op_t;

  typedef struct packed {
    lin_op_t     op;
    logic [5:0]  id;
    logic [63:0] data;                                        // left-justified, 63..56 first
    logic        enhanced;                                    // checksum includes pid
    bit_time_t   bit_time;
  } lin_req_t;

  typedef struct packed {
    logic timeout;                                            // slave silent
    logic bit_err;                                            // readback mismatch
    logic stop_err;                                           // dominant stop bit
    logic cks_err;                                            // bad response checksum
  } lin_err_t;

  typedef struct packed {
    logic [7:0]  pid;
    logic [63:0] data;
    logic [7:0]  cks;                                         // sent or received checksum
    lin_err_t    err;
  } lin_rsp_t;

endpackage
